// ==== hw/exec_consts.svh ====
/*
 * Width constants for the execute stage
 * Data path, register address, instruction word and shift amount
 */

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// ----------------------------------------
// Data path
// ----------------------------------------

`define EXEC_XLEN        32    // RV32 data word
`define EXEC_SHAMT_W     5     // Low rhs bits used by the shifter

// ----------------------------------------
// Instruction fields
// ----------------------------------------

`define EXEC_REG_ADDR_W  5     // x0..x31
`define EXEC_INSTR_W     32    // No compressed forms

`endif

// ==== hw/exec_pkg.sv ====
/*
 * Shared types for the execute stage
 * Data, register address and instruction words
 * ALU, control-flow and write-back encodings
 */

`include "exec_consts.svh"

package exec_pkg;

    // ----------------------------------------
    // Words
    // ----------------------------------------

    typedef logic [`EXEC_XLEN-1:0]       xlen_t;      // Data word
    typedef logic [`EXEC_REG_ADDR_W-1:0] reg_addr_t;  // Register address
    typedef logic [`EXEC_INSTR_W-1:0]    instr_t;     // Instruction word

    // ----------------------------------------
    // Operation encodings
    // ----------------------------------------

    // Integer ALU operation
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Control-flow operation
    typedef enum logic [3:0] {
        CFU_NONE   = 4'd0,     // Plain instruction
        CFU_BEQ    = 4'd1,
        CFU_BNE    = 4'd2,
        CFU_BLT    = 4'd3,
        CFU_BGE    = 4'd4,
        CFU_BLTU   = 4'd5,
        CFU_BGEU   = 4'd6,
        CFU_JAL    = 4'd7,
        CFU_JALR   = 4'd8,
        CFU_MRET   = 4'd9,
        CFU_ECALL  = 4'd10,    // Trap only
        CFU_EBREAK = 4'd11     // Trap only
    } cfu_op_e;

    // Write-back data source
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,        // No register write
        WB_ALU  = 2'd1,        // ALU result
        WB_NPC  = 2'd2         // Link address
    } wb_src_e;

endpackage

// ==== hw/exec_alu.sv ====
/*
 * Combinational integer ALU
 * Add, subtract, bitwise ops, shifts and set-less-than
 * Always-on compare outputs for branch resolution
 */

`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_alu (
    input  exec_pkg::xlen_t   lhs,        // Left operand
    input  exec_pkg::xlen_t   rhs,        // Right operand
    input  exec_pkg::alu_op_e op,         // Operation select
    output exec_pkg::xlen_t   result,     // Operation result
    output logic              cmp_eq,     // lhs == rhs
    output logic              cmp_lt,     // Signed lhs < rhs
    output logic              cmp_ltu     // Unsigned lhs < rhs
);

    // ----------------------------------------
    // Shared arithmetic
    // ----------------------------------------

    exec_pkg::xlen_t          add_out;     // lhs + rhs
    exec_pkg::xlen_t          sub_out;     // lhs - rhs
    exec_pkg::xlen_t          sra_out;     // Arithmetic right shift
    logic [`EXEC_SHAMT_W-1:0] shamt;       // Shift distance

    assign add_out = lhs + rhs;
    assign sub_out = lhs - rhs;
    assign shamt   = rhs[`EXEC_SHAMT_W-1:0];  // Upper rhs bits ignored
    assign sra_out = $signed(lhs) >>> shamt;  // Sign bit replicated

    // ----------------------------------------
    // Comparisons
    // ----------------------------------------

    // Independent of op so branches can use them
    assign cmp_eq  = (lhs == rhs);
    assign cmp_ltu = (lhs < rhs);
    assign cmp_lt  = ($signed(lhs) < $signed(rhs));

    // ----------------------------------------
    // Result select
    // ----------------------------------------

    always_comb begin
        result = '0;                                      // Unused encodings
        case (op)
            exec_pkg::ALU_ADD: begin
                result = add_out;
            end
            exec_pkg::ALU_SUB: begin
                result = sub_out;
            end
            exec_pkg::ALU_AND: begin
                result = lhs & rhs;
            end
            exec_pkg::ALU_OR: begin
                result = lhs | rhs;
            end
            exec_pkg::ALU_XOR: begin
                result = lhs ^ rhs;
            end
            exec_pkg::ALU_SLL: begin
                result = lhs << shamt;
            end
            exec_pkg::ALU_SRL: begin
                result = lhs >> shamt;                    // Zero fill
            end
            exec_pkg::ALU_SRA: begin
                result = sra_out;
            end
            exec_pkg::ALU_SLT: begin
                result = {{(`EXEC_XLEN-1){1'b0}}, cmp_lt};   // 0 or 1
            end
            exec_pkg::ALU_SLTU: begin
                result = {{(`EXEC_XLEN-1){1'b0}}, cmp_ltu};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== hw/exec_cfu.sv ====
/*
 * Control-flow unit
 * Branch and jump resolution with target generation
 * Fetch redirect valid/ack handshake and ecall/ebreak trap flag
 */

`timescale 1ns/1ps

module exec_cfu (
    input  logic              g_clk,       // Clock
    input  logic              g_resetn,    // Sync reset, active low
    input  logic              valid,       // Instruction present at s2
    input  logic              new_instr,   // s2 acceptance this cycle
    input  logic              flush,       // Drop s2 contents
    input  exec_pkg::cfu_op_e op,          // Control-flow operation
    input  exec_pkg::xlen_t   pc,          // Instruction address
    input  exec_pkg::xlen_t   rs1,         // Base for jalr
    input  exec_pkg::xlen_t   imm,         // Offset
    input  exec_pkg::xlen_t   csr_mepc,    // Return address for mret
    input  logic              cmp_eq,      // From ALU
    input  logic              cmp_lt,      // From ALU
    input  logic              cmp_ltu,     // From ALU
    input  logic              cf_ack,      // Fetch took the redirect
    output logic              cf_valid,    // Redirect request
    output exec_pkg::xlen_t   cf_target,   // Redirect address
    output logic              done,        // Instruction may leave s2
    output logic              trap         // ecall or ebreak
);

    logic            taken;     // Op changes control flow
    logic            acked;     // Redirect already accepted
    exec_pkg::xlen_t pc_rel;    // pc + imm
    exec_pkg::xlen_t reg_rel;   // rs1 + imm

    // ----------------------------------------
    // Taken decision
    // ----------------------------------------

    always_comb begin
        case (op)
            exec_pkg::CFU_BEQ:  taken = cmp_eq;
            exec_pkg::CFU_BNE:  taken = !cmp_eq;
            exec_pkg::CFU_BLT:  taken = cmp_lt;
            exec_pkg::CFU_BGE:  taken = !cmp_lt;
            exec_pkg::CFU_BLTU: taken = cmp_ltu;
            exec_pkg::CFU_BGEU: taken = !cmp_ltu;
            exec_pkg::CFU_JAL,
            exec_pkg::CFU_JALR,
            exec_pkg::CFU_MRET: taken = 1'b1;        // Unconditional
            default:            taken = 1'b0;        // None and traps
        endcase
    end

    // ----------------------------------------
    // Target
    // ----------------------------------------

    assign pc_rel  = pc + imm;
    assign reg_rel = rs1 + imm;

    always_comb begin
        cf_target = pc_rel;                          // Branches and jal
        case (op)
            exec_pkg::CFU_JALR: begin
                cf_target    = reg_rel;
                cf_target[0] = 1'b0;                 // Halfword aligned
            end
            exec_pkg::CFU_MRET: begin
                cf_target = csr_mepc;
            end
            default: begin
                cf_target = pc_rel;
            end
        endcase
    end

    // ----------------------------------------
    // Redirect handshake
    // ----------------------------------------

    assign cf_valid = valid && taken && !acked;      // Once per instruction

    // Non-redirecting ops finish at once
    assign done = !taken || acked || (cf_valid && cf_ack);

    assign trap = (op == exec_pkg::CFU_ECALL) || (op == exec_pkg::CFU_EBREAK);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            acked <= 1'b0;
        end else if (new_instr || flush) begin
            acked <= 1'b0;                           // Next instruction
        end else if (cf_valid && cf_ack) begin
            acked <= 1'b1;                           // Held until accepted
        end
    end

endmodule

// ==== hw/exec_wb_reg.sv ====
/*
 * Execute to write-back pipeline register
 * Write-back data select and trap merge
 * s2 acceptance rule, s3 valid/ready and flush
 */

`timescale 1ns/1ps

module exec_wb_reg (
    input  logic                g_clk,       // Clock
    input  logic                g_resetn,    // Sync reset, active low
    input  logic                s2_valid,    // Decode has an instruction
    input  logic                s2_flush,    // Kill s2 and s3
    input  logic                s2_trap,     // Trap from decode
    input  exec_pkg::xlen_t     s2_pc,
    input  exec_pkg::xlen_t     s2_npc,      // Link value
    input  exec_pkg::instr_t    s2_instr,
    input  exec_pkg::reg_addr_t s2_rd,
    input  exec_pkg::wb_src_e   s2_wb_src,
    input  exec_pkg::xlen_t     alu_result,
    input  logic                cfu_done,    // CFU finished with s2
    input  logic                cfu_trap,    // ecall or ebreak
    input  logic                s3_ready,    // Write-back can take entry
    output logic                s2_ready,
    output logic                new_instr,   // Acceptance this cycle
    output logic                s3_valid,
    output exec_pkg::xlen_t     s3_pc,
    output exec_pkg::instr_t    s3_instr,
    output exec_pkg::reg_addr_t s3_rd,
    output exec_pkg::xlen_t     s3_wdata,
    output exec_pkg::wb_src_e   s3_wb_src,
    output logic                s3_trap
);

    exec_pkg::xlen_t wdata;      // Selected write-back value
    logic            trap_any;   // Decode or CFU trap

    // ----------------------------------------
    // Acceptance
    // ----------------------------------------

    // Free slot or one leaving this cycle
    assign s2_ready  = cfu_done && !s2_flush && (!s3_valid || s3_ready);
    assign new_instr = s2_valid && s2_ready;

    // ----------------------------------------
    // Next entry
    // ----------------------------------------

    always_comb begin
        case (s2_wb_src)
            exec_pkg::WB_ALU: wdata = alu_result;
            exec_pkg::WB_NPC: wdata = s2_npc;       // jal / jalr link
            default:          wdata = '0;           // No write
        endcase
    end

    assign trap_any = s2_trap || cfu_trap;

    // ----------------------------------------
    // Output register
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s3_valid <= 1'b0;
        end else if (s2_flush) begin
            s3_valid <= 1'b0;                       // Entry discarded
        end else if (new_instr) begin
            s3_valid <= 1'b1;                       // Replaces or refills
        end else if (s3_ready) begin
            s3_valid <= 1'b0;                       // Drained
        end
    end

    // Payload only moves on acceptance
    always_ff @(posedge g_clk) begin
        if (new_instr) begin
            s3_pc     <= s2_pc;
            s3_instr  <= s2_instr;
            s3_rd     <= s2_rd;
            s3_wdata  <= wdata;
            s3_wb_src <= s2_wb_src;
            s3_trap   <= trap_any;
        end
    end

endmodule

// ==== hw/exec_stage.sv ====
/*
 * Execute stage top level
 * ALU and control-flow unit side by side on the s2 instruction
 * Write-back register owning the pipeline handshake
 */

`timescale 1ns/1ps

module exec_stage (
    input  logic                g_clk,          // Clock
    input  logic                g_resetn,       // Sync reset, active low
    // Decode side
    input  logic                s2_valid,
    output logic                s2_ready,
    input  logic                s2_flush,
    input  logic                s2_trap,
    input  exec_pkg::xlen_t     s2_pc,
    input  exec_pkg::xlen_t     s2_npc,
    input  exec_pkg::instr_t    s2_instr,
    input  exec_pkg::reg_addr_t s2_rd,
    input  exec_pkg::xlen_t     s2_rs1_data,    // jalr base
    input  exec_pkg::xlen_t     s2_alu_lhs,
    input  exec_pkg::xlen_t     s2_alu_rhs,
    input  exec_pkg::xlen_t     s2_imm,
    input  exec_pkg::alu_op_e   s2_alu_op,
    input  exec_pkg::cfu_op_e   s2_cfu_op,
    input  exec_pkg::wb_src_e   s2_wb_src,
    input  exec_pkg::xlen_t     csr_mepc,       // mret target
    // Fetch redirect
    output logic                cf_valid,
    input  logic                cf_ack,
    output exec_pkg::xlen_t     cf_target,
    // Write-back side
    output logic                s3_valid,
    input  logic                s3_ready,
    output exec_pkg::xlen_t     s3_pc,
    output exec_pkg::instr_t    s3_instr,
    output exec_pkg::reg_addr_t s3_rd,
    output exec_pkg::xlen_t     s3_wdata,
    output exec_pkg::wb_src_e   s3_wb_src,
    output logic                s3_trap
);

    exec_pkg::xlen_t alu_result;   // ALU to write-back select
    logic            cmp_eq;       // Compare bits to CFU
    logic            cmp_lt;
    logic            cmp_ltu;
    logic            cfu_done;     // CFU releases s2
    logic            cfu_trap;
    logic            new_instr;    // Acceptance at s2

    // ----------------------------------------
    // Units
    // ----------------------------------------

    exec_alu u_alu (
        .lhs     (s2_alu_lhs),
        .rhs     (s2_alu_rhs),
        .op      (s2_alu_op),
        .result  (alu_result),
        .cmp_eq  (cmp_eq),
        .cmp_lt  (cmp_lt),
        .cmp_ltu (cmp_ltu)
    );

    exec_cfu u_cfu (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .valid     (s2_valid),
        .new_instr (new_instr),
        .flush     (s2_flush),
        .op        (s2_cfu_op),
        .pc        (s2_pc),
        .rs1       (s2_rs1_data),
        .imm       (s2_imm),
        .csr_mepc  (csr_mepc),
        .cmp_eq    (cmp_eq),
        .cmp_lt    (cmp_lt),
        .cmp_ltu   (cmp_ltu),
        .cf_ack    (cf_ack),
        .cf_valid  (cf_valid),
        .cf_target (cf_target),
        .done      (cfu_done),
        .trap      (cfu_trap)
    );

    // ----------------------------------------
    // Pipeline register
    // ----------------------------------------

    exec_wb_reg u_wb_reg (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .s2_valid   (s2_valid),
        .s2_flush   (s2_flush),
        .s2_trap    (s2_trap),
        .s2_pc      (s2_pc),
        .s2_npc     (s2_npc),
        .s2_instr   (s2_instr),
        .s2_rd      (s2_rd),
        .s2_wb_src  (s2_wb_src),
        .alu_result (alu_result),
        .cfu_done   (cfu_done),
        .cfu_trap   (cfu_trap),
        .s3_ready   (s3_ready),
        .s2_ready   (s2_ready),
        .new_instr  (new_instr),
        .s3_valid   (s3_valid),
        .s3_pc      (s3_pc),
        .s3_instr   (s3_instr),
        .s3_rd      (s3_rd),
        .s3_wdata   (s3_wdata),
        .s3_wb_src  (s3_wb_src),
        .s3_trap    (s3_trap)
    );

endmodule

// ==== test/tb_exec_tasks.svh ====
/*
 * LFSR operands, drive helpers and compare tasks
 * ALU reference model and the directed tests
 */

// ----------------------------------------
// Stimulus
// ----------------------------------------

// x^16 + x^14 + x^13 + x^11, one step per bit
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic exec_pkg::xlen_t rand_word();
    exec_pkg::xlen_t w;
    for (int i = 0; i < `EXEC_XLEN; i++) begin
        w[i] = lfsr_bit();
    end
    return w;
endfunction

function automatic exec_pkg::reg_addr_t rand_reg_addr();
    exec_pkg::reg_addr_t a;
    for (int i = 0; i < `EXEC_REG_ADDR_W; i++) begin
        a[i] = lfsr_bit();
    end
    return a;
endfunction

task automatic clear_inputs();
    s2_valid    = 1'b0;
    s2_flush    = 1'b0;
    s2_trap     = 1'b0;
    s2_pc       = '0;
    s2_npc      = '0;
    s2_instr    = '0;
    s2_rd       = '0;
    s2_rs1_data = '0;
    s2_alu_lhs  = '0;
    s2_alu_rhs  = '0;
    s2_imm      = '0;
    s2_alu_op   = exec_pkg::ALU_ADD;
    s2_cfu_op   = exec_pkg::CFU_NONE;
    s2_wb_src   = exec_pkg::WB_NONE;
    csr_mepc    = '0;
    cf_ack      = 1'b0;
    s3_ready    = 1'b1;                  // Write-back normally free
endtask

task automatic drive_slot();
    @(posedge g_clk);
    #2;                                  // Inputs change after the edge
endtask

// Puts one instruction on the decode side
task automatic present(exec_pkg::cfu_op_e cfu, exec_pkg::alu_op_e alu,
                       exec_pkg::wb_src_e src, exec_pkg::xlen_t lhs, exec_pkg::xlen_t rhs);
    s2_valid    = 1'b1;
    s2_trap     = 1'b0;
    s2_cfu_op   = cfu;
    s2_alu_op   = alu;
    s2_wb_src   = src;
    s2_alu_lhs  = lhs;
    s2_alu_rhs  = rhs;
    s2_pc       = rand_word();
    s2_npc      = s2_pc + 32'd4;         // Link is next sequential pc
    s2_instr    = rand_word();
    s2_rd       = rand_reg_addr();
    s2_rs1_data = rand_word();
    s2_imm      = rand_word();
    csr_mepc    = rand_word();
endtask

// Acceptance edge, then withdraw and move to the s3 sample point
task automatic finish_accept();
    @(posedge g_clk);
    #2;
    s2_valid = 1'b0;
    cf_ack   = 1'b0;
    @(negedge g_clk);
endtask

task automatic wait_accept();
    @(negedge g_clk);
    while (!s2_ready) begin
        @(negedge g_clk);                // Watchdog bounds the wait
    end
    finish_accept();
endtask

// ----------------------------------------
// Compare tasks
// ----------------------------------------

task automatic check_xlen(string name, exec_pkg::xlen_t got, exec_pkg::xlen_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_instr(string name, exec_pkg::instr_t got, exec_pkg::instr_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_reg_addr(string name, exec_pkg::reg_addr_t got, exec_pkg::reg_addr_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
endtask

task automatic check_wb_src(string name, exec_pkg::wb_src_e got, exec_pkg::wb_src_e exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
endtask

task automatic report_result(string name, int errs_before);
    test_count++;
    if (error_count == errs_before) begin
        $display("%-24s ok", name);
    end else begin
        $display("%-24s %0d mismatches", name, error_count - errs_before);
    end
endtask

// ----------------------------------------
// Reference model
// ----------------------------------------

function automatic exec_pkg::xlen_t alu_model(exec_pkg::alu_op_e op,
                                              exec_pkg::xlen_t a, exec_pkg::xlen_t b);
    logic [`EXEC_SHAMT_W-1:0] sh;
    sh = b[`EXEC_SHAMT_W-1:0];           // Only low bits shift
    case (op)
        exec_pkg::ALU_ADD:  return a + b;
        exec_pkg::ALU_SUB:  return a - b;
        exec_pkg::ALU_AND:  return a & b;
        exec_pkg::ALU_OR:   return a | b;
        exec_pkg::ALU_XOR:  return a ^ b;
        exec_pkg::ALU_SLL:  return a << sh;
        exec_pkg::ALU_SRL:  return a >> sh;
        exec_pkg::ALU_SRA:  return exec_pkg::xlen_t'($signed(a) >>> sh);
        exec_pkg::ALU_SLT:  return exec_pkg::xlen_t'($signed(a) < $signed(b));
        exec_pkg::ALU_SLTU: return exec_pkg::xlen_t'(a < b);
        default:            return '0;
    endcase
endfunction

// ----------------------------------------
// Directed tests
// ----------------------------------------

task automatic reset_values();
    int errs;
    errs = error_count;
    @(negedge g_clk);
    check_bit("s3_valid", s3_valid, 1'b0);
    check_bit("cf_valid", cf_valid, 1'b0);
    report_result("reset_values", errs);
endtask

task automatic alu_results();
    int                  errs;
    exec_pkg::alu_op_e   op;
    exec_pkg::xlen_t     exp;
    exec_pkg::xlen_t     exp_pc;
    exec_pkg::instr_t    exp_instr;
    exec_pkg::reg_addr_t exp_rd;
    errs = error_count;
    for (int i = 0; i <= int'(exec_pkg::ALU_SLTU); i++) begin
        op = exec_pkg::alu_op_e'(i);
        drive_slot();
        present(exec_pkg::CFU_NONE, op, exec_pkg::WB_ALU, rand_word(), rand_word());
        exp       = alu_model(op, s2_alu_lhs, s2_alu_rhs);
        exp_pc    = s2_pc;               // Carried through unchanged
        exp_instr = s2_instr;
        exp_rd    = s2_rd;
        wait_accept();
        check_bit("s3_valid", s3_valid, 1'b1);
        check_xlen("s3_wdata", s3_wdata, exp);
        check_wb_src("s3_wb_src", s3_wb_src, exec_pkg::WB_ALU);
        check_bit("s3_trap", s3_trap, 1'b0);
        check_xlen("s3_pc", s3_pc, exp_pc);
        check_instr("s3_instr", s3_instr, exp_instr);
        check_reg_addr("s3_rd", s3_rd, exp_rd);
    end
    report_result("alu_results", errs);
endtask

task automatic branch_redirects();
    int              errs;
    exec_pkg::xlen_t target;
    errs = error_count;
    // Taken beq, fetch slow to acknowledge
    drive_slot();
    present(exec_pkg::CFU_BEQ, exec_pkg::ALU_SUB, exec_pkg::WB_NONE, 32'h1234_5678, 32'h1234_5678);
    target = s2_pc + s2_imm;
    repeat (3) begin
        @(negedge g_clk);
        check_bit("cf_valid", cf_valid, 1'b1);
        check_xlen("cf_target", cf_target, target);
        check_bit("s2_ready", s2_ready, 1'b0);   // Held until ack
    end
    drive_slot();
    cf_ack = 1'b1;
    wait_accept();
    check_bit("s3_valid", s3_valid, 1'b1);
    check_bit("cf_valid", cf_valid, 1'b0);
    // Acked bltu parked behind a full s3 must not redirect twice
    drive_slot();
    s3_ready = 1'b0;
    present(exec_pkg::CFU_NONE, exec_pkg::ALU_ADD, exec_pkg::WB_ALU, rand_word(), rand_word());
    wait_accept();
    drive_slot();
    present(exec_pkg::CFU_BLTU, exec_pkg::ALU_SUB, exec_pkg::WB_NONE, 32'h1, 32'h2);
    cf_ack = 1'b1;
    drive_slot();                        // Redirect taken at this edge
    cf_ack = 1'b0;
    @(negedge g_clk);
    check_bit("cf_valid", cf_valid, 1'b0);
    check_bit("s2_ready", s2_ready, 1'b0);
    drive_slot();
    s3_ready = 1'b1;
    wait_accept();
    check_bit("s3_valid", s3_valid, 1'b1);
    check_bit("cf_valid", cf_valid, 1'b0);
    // Not-taken bne goes straight through
    drive_slot();
    present(exec_pkg::CFU_BNE, exec_pkg::ALU_SUB, exec_pkg::WB_NONE, 32'h55, 32'h55);
    @(negedge g_clk);
    check_bit("cf_valid", cf_valid, 1'b0);
    check_bit("s2_ready", s2_ready, 1'b1);
    finish_accept();
    check_bit("s3_valid", s3_valid, 1'b1);
    check_bit("cf_valid", cf_valid, 1'b0);
    report_result("branch_redirects", errs);
endtask

task automatic jump_targets();
    int                errs;
    exec_pkg::xlen_t   target;
    exec_pkg::xlen_t   link;
    exec_pkg::cfu_op_e jump_ops [3] = '{exec_pkg::CFU_JAL, exec_pkg::CFU_JALR, exec_pkg::CFU_MRET};
    errs = error_count;
    foreach (jump_ops[i]) begin
        drive_slot();
        present(jump_ops[i], exec_pkg::ALU_ADD, exec_pkg::WB_NPC, rand_word(), rand_word());
        link = s2_npc;
        case (jump_ops[i])
            exec_pkg::CFU_JALR: target = (s2_rs1_data + s2_imm) & ~32'h1;
            exec_pkg::CFU_MRET: target = csr_mepc;
            default:            target = s2_pc + s2_imm;
        endcase
        @(negedge g_clk);
        check_bit("cf_valid", cf_valid, 1'b1);
        check_xlen("cf_target", cf_target, target);
        drive_slot();
        cf_ack = 1'b1;
        wait_accept();
        check_xlen("s3_wdata", s3_wdata, link);
        check_wb_src("s3_wb_src", s3_wb_src, exec_pkg::WB_NPC);
    end
    report_result("jump_targets", errs);
endtask

task automatic backpressure_and_flush();
    int              errs;
    exec_pkg::xlen_t held;
    errs = error_count;
    drive_slot();
    s3_ready = 1'b0;
    present(exec_pkg::CFU_NONE, exec_pkg::ALU_XOR, exec_pkg::WB_ALU, rand_word(), rand_word());
    held = alu_model(exec_pkg::ALU_XOR, s2_alu_lhs, s2_alu_rhs);
    wait_accept();
    drive_slot();
    present(exec_pkg::CFU_NONE, exec_pkg::ALU_ADD, exec_pkg::WB_ALU, rand_word(), rand_word());
    repeat (3) begin
        @(negedge g_clk);
        check_bit("s2_ready", s2_ready, 1'b0);
        check_bit("s3_valid", s3_valid, 1'b1);
        check_xlen("s3_wdata", s3_wdata, held);  // Payload frozen
    end
    drive_slot();
    s2_flush = 1'b1;                     // s3 still stalled
    drive_slot();
    @(negedge g_clk);
    check_bit("s3_valid", s3_valid, 1'b0);   // Cleared despite the stall
    check_bit("s2_ready", s2_ready, 1'b0);   // s3 empty, only flush blocks
    drive_slot();
    s2_flush = 1'b0;
    s2_valid = 1'b0;                     // Flushed instruction dropped
    s3_ready = 1'b1;
    @(negedge g_clk);
    check_bit("s3_valid", s3_valid, 1'b0);
    report_result("backpressure_and_flush", errs);
endtask

task automatic trap_flags();
    int                errs;
    exec_pkg::cfu_op_e trap_ops [3] = '{exec_pkg::CFU_ECALL, exec_pkg::CFU_EBREAK,
                                         exec_pkg::CFU_NONE};
    errs = error_count;
    foreach (trap_ops[i]) begin
        drive_slot();
        present(trap_ops[i], exec_pkg::ALU_ADD, exec_pkg::WB_NONE, rand_word(), rand_word());
        s2_trap = (i == 2);              // Last case traps from decode
        wait_accept();
        s2_trap = 1'b0;
        check_bit("s3_valid", s3_valid, 1'b1);
        check_bit("s3_trap", s3_trap, 1'b1);
        check_xlen("s3_wdata", s3_wdata, '0);
    end
    report_result("trap_flags", errs);
endtask

// ==== test/tb_exec_stage.sv ====
/*
 * Testbench top for the execute stage
 * Clock, reset, watchdog, DUT instance and test sequence
 */

`timescale 1ns/1ps

`include "exec_consts.svh"

module tb_exec_stage;

    localparam int NUM_TESTS  = 6;         // Sizes the watchdog
    localparam int CLK_PERIOD = 40;        // ns

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------

    logic                g_clk = 1'b0;
    logic                g_resetn;
    logic                s2_valid;
    logic                s2_ready;
    logic                s2_flush;
    logic                s2_trap;
    exec_pkg::xlen_t     s2_pc;
    exec_pkg::xlen_t     s2_npc;
    exec_pkg::instr_t    s2_instr;
    exec_pkg::reg_addr_t s2_rd;
    exec_pkg::xlen_t     s2_rs1_data;
    exec_pkg::xlen_t     s2_alu_lhs;
    exec_pkg::xlen_t     s2_alu_rhs;
    exec_pkg::xlen_t     s2_imm;
    exec_pkg::alu_op_e   s2_alu_op;
    exec_pkg::cfu_op_e   s2_cfu_op;
    exec_pkg::wb_src_e   s2_wb_src;
    exec_pkg::xlen_t     csr_mepc;
    logic                cf_valid;
    logic                cf_ack;
    exec_pkg::xlen_t     cf_target;
    logic                s3_valid;
    logic                s3_ready;
    exec_pkg::xlen_t     s3_pc;
    exec_pkg::instr_t    s3_instr;
    exec_pkg::reg_addr_t s3_rd;
    exec_pkg::xlen_t     s3_wdata;
    exec_pkg::wb_src_e   s3_wb_src;
    logic                s3_trap;

    logic [15:0] lfsr_state;               // Operand generator state
    int          test_count;
    int          check_count;
    int          error_count;

    `include "tb_exec_tasks.svh"

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;   // 40 ns period

    exec_stage u_dut (.*);

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------

    initial begin : watchdog
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog expired before the test sequence completed");
        $display("TESTS FAILED");
        $finish;
    end

    // ----------------------------------------
    // Sequence
    // ----------------------------------------

    initial begin : main
        test_count  = 0;
        check_count = 0;
        error_count = 0;
        lfsr_state  = 16'd55;                  // Fixed seed
        g_resetn    = 1'b0;
        clear_inputs();
        repeat (5) @(posedge g_clk);           // Reset held 5 cycles
        #2;
        g_resetn = 1'b1;
        reset_values();
        alu_results();
        branch_redirects();
        jump_targets();
        backpressure_and_flush();
        trap_flags();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== exec_stage.f ====
+incdir+hw
+incdir+test
hw/exec_pkg.sv
hw/exec_alu.sv
hw/exec_cfu.sv
hw/exec_wb_reg.sv
hw/exec_stage.sv
test/tb_exec_stage.sv

// ==== Bender.yml ====
package:
  name: exec_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/exec_pkg.sv
      - hw/exec_alu.sv
      - hw/exec_cfu.sv
      - hw/exec_wb_reg.sv
      - hw/exec_stage.sv
  - target: test
    include_dirs:
      - hw
      - test
    files:
      - test/tb_exec_stage.sv
